/* hw/tiny_pkg.sv */
package tiny_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_wait_irq,
        st_halted,
        st_error
    } core_state_t;

    typedef struct packed {
        word_t    address;
        word_t    data_out;
        logic     rd;
        byte_en_t wr;
    } mem_req_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd_idx; // Zero when the instruction has no destination
        word_t    value;
    } commit_t;

    localparam word_t IRQ_MASK_ADDR = 32'hFFFF_FFF0;
    localparam word_t IRQ_VECTOR    = 32'h0000_0040;
    localparam word_t RESET_PC      = 32'h0000_0000;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam word_t INSN_EBREAK = 32'h0010_0073; // System words are matched in full
    localparam word_t INSN_WFI    = 32'h1050_0073;
    localparam word_t INSN_MRET   = 32'h3020_0073;

    localparam byte_en_t BE_WORD = 4'b1111;

endpackage

/* hw/tiny_mem.sv */
module tiny_mem import tiny_pkg::*; #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_STATES = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t mem_req,
    output word_t    data_in,
    output logic     ready,
    output logic     mask_wr,
    output word_t    mask_data,
    input  logic     load_en,
    input  word_t    load_addr,
    input  word_t    load_data
);
    localparam int ADDR_BITS = $clog2(MEM_WORDS);
    localparam int CNT_BITS  = $clog2(WAIT_STATES + 2);

    word_t                mem [MEM_WORDS];
    logic [CNT_BITS-1:0]  wait_cnt;
    logic                 done;
    logic                 active;
    logic                 is_mask;
    logic [ADDR_BITS-1:0] idx;
    logic [ADDR_BITS-1:0] load_idx;

    assign active   = mem_req.rd || (mem_req.wr != '0);
    assign is_mask  = mem_req.address == IRQ_MASK_ADDR;
    assign idx      = mem_req.address[ADDR_BITS+1:2]; // Byte address on the bus, word array
    assign load_idx = load_addr[ADDR_BITS+1:2];
    assign ready    = active && !done && (wait_cnt == CNT_BITS'(WAIT_STATES));
    assign data_in  = is_mask ? '0 : mem[idx];

    always_ff @(posedge clk) begin
        if (!reset) begin
            wait_cnt <= '0;
            done     <= 1'b0;
            mask_wr  <= 1'b0;
        end else begin
            done    <= ready; // Forces one idle cycle between accesses
            mask_wr <= ready && (mem_req.wr != '0) && is_mask;
            if (ready || !active || done)
                wait_cnt <= '0;
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (ready && !is_mask) begin
            for (int b = 0; b < 4; b++)
                if (mem_req.wr[b])
                    mem[idx][8*b +: 8] <= mem_req.data_out[8*b +: 8];
        end
        if (ready && is_mask)
            mask_data <= mem_req.data_out;
    end

endmodule

/* hw/tiny_irq_regs.sv */
module tiny_irq_regs import tiny_pkg::*; #(
    parameter int INTERRUPT_BITS = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [INTERRUPT_BITS-1:0] interrupt,
    input  logic                      mask_wr,
    input  word_t                     mask_data,
    input  logic                      irq_ack,
    output logic                      irq_req
);
    logic [INTERRUPT_BITS-1:0] mask;
    logic [INTERRUPT_BITS-1:0] pending;

    always_ff @(posedge clk) begin
        if (!reset) begin
            mask    <= '0;
            pending <= '0;
        end else begin
            if (mask_wr)
                mask <= mask_data[INTERRUPT_BITS-1:0];
            // Handler entry drops every request, masked lines included
            if (irq_ack)
                pending <= '0;
            else
                pending <= pending | interrupt;
        end
    end

    assign irq_req = |(pending & mask);

endmodule

/* hw/tiny_core.sv */
module tiny_core import tiny_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output mem_req_t mem_req,
    input  word_t    data_in,
    input  logic     ready,
    input  logic     irq_req,
    output logic     irq_ack,
    output logic     commit_valid,
    output commit_t  commit,
    output logic     hlt,
    output logic     wfi,
    output logic     error
);
    core_state_t state;
    word_t       pc;
    word_t       npc;
    word_t       saved_pc;
    word_t       ir;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       result;
    logic        in_irq;
    word_t       regs [32];

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd_idx;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    logic       is_lui, is_imm, is_reg, is_load, is_store, is_branch, is_jal;
    logic       is_ebreak, is_wfi, is_mret;
    logic       legal;
    logic       has_dest;
    logic       taken;
    word_t      alu_b;
    word_t      alu_out;
    word_t      exec_value;
    word_t      exec_npc;
    logic       launch;
    logic       take_irq;
    word_t      launch_pc;

    assign opcode  = ir[6:0];
    assign rd_idx  = ir[11:7];
    assign funct3  = ir[14:12];
    assign rs1_idx = ir[19:15];
    assign rs2_idx = ir[24:20];
    assign funct7  = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
    assign imm_u = {ir[31:12], 12'h000};

    assign is_lui    = opcode == OP_LUI;
    assign is_imm    = opcode == OP_IMM;
    assign is_reg    = opcode == OP_REG;
    assign is_load   = opcode == OP_LOAD;
    assign is_store  = opcode == OP_STORE;
    assign is_branch = opcode == OP_BRANCH;
    assign is_jal    = opcode == OP_JAL;
    assign is_ebreak = ir == INSN_EBREAK;
    assign is_wfi    = ir == INSN_WFI;
    assign is_mret   = ir == INSN_MRET;
    assign has_dest  = is_lui || is_imm || is_reg || is_load || is_jal;

    always_comb begin
        case (opcode)
            OP_LUI, OP_JAL:    legal = 1'b1;
            OP_IMM:            legal = funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
            OP_REG:            legal = (funct7 == 7'b0000000
                                        && funct3 inside {3'b000, 3'b100, 3'b110, 3'b111})
                                       || (funct7 == 7'b0100000 && funct3 == 3'b000);
            OP_LOAD, OP_STORE: legal = funct3 == 3'b010; // Word access only
            OP_BRANCH:         legal = funct3 inside {3'b000, 3'b001};
            OP_SYSTEM:         legal = is_ebreak || is_wfi || is_mret;
            default:           legal = 1'b0;
        endcase
    end

    assign taken = (rs1_val == rs2_val) ^ funct3[0]; // BNE inverts the BEQ compare
    assign alu_b = is_reg ? rs2_val : imm_i;

    always_comb begin
        case (funct3)
            3'b100:  alu_out = rs1_val ^ alu_b;
            3'b110:  alu_out = rs1_val | alu_b;
            3'b111:  alu_out = rs1_val & alu_b;
            default: alu_out = (is_reg && funct7[5]) ? rs1_val - alu_b : rs1_val + alu_b;
        endcase
    end

    assign exec_value = is_lui ? imm_u : (is_jal ? pc + 32'd4 : alu_out);
    assign exec_npc   = is_jal ? pc + imm_j :
                        (is_branch && taken) ? pc + imm_b :
                        is_mret ? saved_pc : pc + 32'd4;

    // A fetch is launched after reset, after each retired instruction and on wake from WFI
    always_comb begin
        launch_pc = (state == st_writeback) ? npc : pc;
        case (state)
            st_fetch:     launch = !mem_req.rd;
            st_writeback: launch = !is_ebreak && !is_wfi;
            st_wait_irq:  launch = irq_req;
            default:      launch = 1'b0;
        endcase
    end

    assign take_irq = launch && irq_req && !in_irq;

    assign commit_valid  = state == st_writeback;
    assign commit.pc     = pc;
    assign commit.rd_idx = has_dest ? rd_idx : '0;
    assign commit.value  = (has_dest && rd_idx != '0) ? result : '0;

    always_ff @(posedge clk) begin
        if (state == st_writeback && has_dest && rd_idx != '0)
            regs[rd_idx] <= result;
        if (state == st_decode) begin
            rs1_val <= (rs1_idx == '0) ? '0 : regs[rs1_idx]; // x0 always reads zero
            rs2_val <= (rs2_idx == '0) ? '0 : regs[rs2_idx];
        end
        if (state == st_fetch && mem_req.rd && ready)
            ir <= data_in;
        if (state == st_execute) begin
            result <= exec_value;
            npc    <= exec_npc;
        end
        if (state == st_memory && ready && mem_req.rd)
            result <= data_in;
        if (take_irq)
            saved_pc <= launch_pc;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= st_fetch;
            pc      <= RESET_PC;
            in_irq  <= 1'b0;
            mem_req <= '0;
            irq_ack <= 1'b0;
            hlt     <= 1'b0;
            wfi     <= 1'b0;
            error   <= 1'b0;
        end else begin
            irq_ack <= 1'b0;
            if (launch) begin
                state      <= st_fetch;
                mem_req.rd <= 1'b1;
                wfi        <= 1'b0;
                if (take_irq) begin
                    pc              <= IRQ_VECTOR; // Entry itself retires nothing
                    mem_req.address <= IRQ_VECTOR;
                    in_irq          <= 1'b1;
                    irq_ack         <= 1'b1;
                end else begin
                    pc              <= launch_pc;
                    mem_req.address <= launch_pc;
                end
            end
            case (state)
                st_fetch: begin
                    if (mem_req.rd && ready) begin
                        mem_req.rd <= 1'b0;
                        state      <= st_decode;
                    end
                end
                st_decode: begin
                    if (!legal) begin
                        state <= st_error;
                        error <= 1'b1;
                    end else begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (is_load || is_store) begin
                        mem_req.address  <= rs1_val + (is_store ? imm_s : imm_i);
                        mem_req.data_out <= rs2_val;
                        mem_req.rd       <= is_load;
                        mem_req.wr       <= is_store ? BE_WORD : '0;
                        state            <= st_memory;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_memory: begin
                    if (ready) begin
                        mem_req.rd <= 1'b0;
                        mem_req.wr <= '0;
                        state      <= st_writeback;
                    end
                end
                st_writeback: begin
                    if (is_mret)
                        in_irq <= 1'b0;
                    if (is_ebreak) begin
                        state <= st_halted;
                        hlt   <= 1'b1;
                    end else if (is_wfi) begin
                        state <= st_wait_irq;
                        wfi   <= 1'b1;
                        pc    <= npc; // Resume point after the handler
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* hw/tiny_soc.sv */
module tiny_soc import tiny_pkg::*; #(
    parameter int INTERRUPT_BITS = 2,
    parameter int MEM_WORDS      = 256,
    parameter int WAIT_STATES    = 1
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [INTERRUPT_BITS-1:0] interrupt,
    input  logic                      load_en,
    input  word_t                     load_addr,
    input  word_t                     load_data,
    output logic                      commit_valid,
    output commit_t                   commit,
    output logic                      hlt,
    output logic                      wfi,
    output logic                      error
);
    mem_req_t mem_req;
    word_t    mem_rdata;
    logic     mem_ready;
    logic     irq_req;
    logic     irq_ack;
    logic     mask_wr;
    word_t    mask_data;

    tiny_core core_i (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .data_in      (mem_rdata),
        .ready        (mem_ready),
        .irq_req      (irq_req),
        .irq_ack      (irq_ack),
        .commit_valid (commit_valid),
        .commit       (commit),
        .hlt          (hlt),
        .wfi          (wfi),
        .error        (error)
    );

    tiny_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) mem_i (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .data_in   (mem_rdata),
        .ready     (mem_ready),
        .mask_wr   (mask_wr),
        .mask_data (mask_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    tiny_irq_regs #(
        .INTERRUPT_BITS (INTERRUPT_BITS)
    ) irq_regs_i (
        .clk       (clk),
        .reset     (reset),
        .interrupt (interrupt),
        .mask_wr   (mask_wr),
        .mask_data (mask_data),
        .irq_ack   (irq_ack),
        .irq_req   (irq_req)
    );

endmodule

/* tb/tiny_soc_assert.sv */
module tiny_soc_assert import tiny_pkg::*; (
    input logic     clk,
    input logic     reset,
    input mem_req_t mem_req,
    input logic     ready,
    input logic     commit_valid,
    input logic     hlt,
    input logic     error,
    input logic     irq_ack
);
    logic active;

    assign active = mem_req.rd || (mem_req.wr != '0);

    req_stable: assert property (@(posedge clk) disable iff (!reset)
        active && !ready |=> $stable(mem_req))
        else $error("Memory request changed before ready");

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(mem_req.rd && mem_req.wr != '0))
        else $error("Read and write strobes active together");

    no_commit_stopped: assert property (@(posedge clk) disable iff (!reset)
        !(commit_valid && (hlt || error)))
        else $error("Commit after halt or error");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!reset)
        irq_ack |=> !irq_ack)
        else $error("Interrupt acknowledge longer than one cycle");

endmodule

bind tiny_core tiny_soc_assert tiny_soc_assert_i (
    .clk          (clk),
    .reset        (reset),
    .mem_req      (mem_req),
    .ready        (ready),
    .commit_valid (commit_valid),
    .hlt          (hlt),
    .error        (error),
    .irq_ack      (irq_ack)
);

/* tb/tb_tiny_soc.sv */
module tb_tiny_soc;
    import tiny_pkg::*;

    localparam int INTERRUPT_BITS = 2;
    localparam int TRACE_WORDS    = 256;
    localparam int SETTLE_CYCLES  = 10;

    logic                      clk;
    logic                      reset;
    logic [INTERRUPT_BITS-1:0] interrupt;
    logic                      load_en;
    word_t                     load_addr;
    word_t                     load_data;
    logic                      commit_valid;
    commit_t                   commit;
    logic                      hlt;
    logic                      wfi;
    logic                      error;

    word_t       trace [TRACE_WORDS];
    int          pos;
    int          value_errors;
    int          flow_errors;
    logic        timed_out;
    logic [31:0] lfsr_state;

    tiny_soc #(
        .INTERRUPT_BITS (INTERRUPT_BITS),
        .MEM_WORDS      (256),
        .WAIT_STATES    (1)
    ) tiny_soc_i (
        .clk          (clk),
        .reset        (reset),
        .interrupt    (interrupt),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .commit_valid (commit_valid),
        .commit       (commit),
        .hlt          (hlt),
        .wfi          (wfi),
        .error        (error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic random_delay(output int delay);
        delay = 0;
        for (int i = 0; i < 4; i++) begin
            delay      = (delay << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_field(input string name, input word_t expected, input word_t actual,
                               input int idx);
        if (actual !== expected) begin
            $display("Error %s: expected %h, got %h (record %0d)", name, expected, actual, idx);
            value_errors++;
        end
    endtask

    // Words go in while the core is held in reset
    task automatic load_program();
        int count;
        count = int'(trace[pos]);
        pos++;
        reset   = 1'b0;
        load_en = 1'b1;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            load_addr = trace[pos];
            load_data = trace[pos + 1];
            pos += 2;
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b1;
    endtask

    task automatic run_section(input int section);
        int   count;
        int   base;
        int   limit;
        int   cycles;
        int   seen;
        int   settle;
        int   irq_delay;
        logic irq_fired;
        load_program();
        count     = int'(trace[pos]);
        base      = pos + 1;
        pos       = base + 3 * count;
        limit     = 40 * count + 200;
        cycles    = 0;
        seen      = 0;
        settle    = 0;
        irq_delay = -1;
        irq_fired = 1'b0;
        while (settle < SETTLE_CYCLES && !timed_out) begin
            @(negedge clk);
            cycles++;
            interrupt = '0;
            if (commit_valid) begin
                if (seen < count) begin
                    check_field("commit.pc", trace[base + 3 * seen], commit.pc, seen);
                    check_field("commit.rd_idx", trace[base + 3 * seen + 1],
                                {27'b0, commit.rd_idx}, seen);
                    check_field("commit.value", trace[base + 3 * seen + 2], commit.value, seen);
                end else begin
                    $display("Section %0d: extra commit at pc %h", section, commit.pc);
                    flow_errors++;
                end
                check_field("wfi", 32'h0, {31'b0, wfi}, seen); // A retiring core is not waiting
                seen++;
                if (seen == 3)
                    interrupt[1] = 1'b1; // Masked line, no handler entry expected
            end
            if (wfi && !irq_fired) begin
                if (irq_delay < 0)
                    random_delay(irq_delay);
                if (irq_delay == 0) begin
                    interrupt[0] = 1'b1;
                    irq_fired    = 1'b1;
                end else begin
                    irq_delay--;
                end
            end
            if (hlt || error)
                settle++;
            if (cycles >= limit) begin
                $display("Section %0d: the core never halted within %0d cycles", section, limit);
                flow_errors++;
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            if (seen != count) begin
                $display("Section %0d: saw %0d commits where %0d were expected",
                         section, seen, count);
                flow_errors++;
            end
            check_field("hlt", trace[pos], {31'b0, hlt}, section);
            check_field("error", trace[pos + 1], {31'b0, error}, section);
            check_field("wfi", 32'h0, {31'b0, wfi}, section);
        end
        pos += 2;
    endtask

    initial begin
        reset        = 1'b0;
        interrupt    = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        value_errors = 0;
        flow_errors  = 0;
        timed_out    = 1'b0;
        lfsr_state   = 32'h0931_8c17;
        $readmemh("tb/tiny_soc_trace.txt", trace);
        if ($isunknown(trace[0])) begin
            $display("The trace file could not be read");
            flow_errors++;
        end else begin
            pos = 1;
            for (int s = 0; s < int'(trace[0]) && !timed_out; s++)
                run_section(s);
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* sources.f */
hw/tiny_pkg.sv
hw/tiny_mem.sv
hw/tiny_irq_regs.sv
hw/tiny_core.sv
hw/tiny_soc.sv
tb/tiny_soc_assert.sv
tb/tb_tiny_soc.sv

/* Bender.yml */
package:
  name: tiny_soc

sources:
  - hw/tiny_pkg.sv
  - hw/tiny_mem.sv
  - hw/tiny_irq_regs.sv
  - hw/tiny_core.sv
  - hw/tiny_soc.sv
  - target: test
    files:
      - tb/tiny_soc_assert.sv
      - tb/tb_tiny_soc.sv

/* tb/tiny_soc_trace.txt */
// Section count, then per section: word count and lines of byte address and program word,
// commit count and lines of pc, rd_idx and value, then the final hlt and error flags
2
1A
00 123450B7 // OP_LUI x1
04 FFF00113 // OP_IMM addi x2, x0, -1
08 0F017193
0C 6780E213
10 FFF24293
14 00320333 // OP_REG add x6
18 404183B3 // sub x7
1C 00737433
20 0011E4B3
24 00434533
28 00508013 // Destination x0
2C 10402023 // OP_STORE to 0x100
30 10002583 // OP_LOAD from 0x100
34 00458463 // OP_BRANCH beq taken
38 00100613
3C 044006EF // OP_JAL to 0x80
40 05500713 // Handler at IRQ_VECTOR
44 30200073 // mret
80 00008463 // beq not taken
84 00459463 // bne not taken
88 00009463 // bne taken
8C 00200613
90 00100793
94 FEF02823 // Store to IRQ_MASK_ADDR
98 10500073 // wfi
9C 00100073 // ebreak
18
00 1 12345000
04 2 FFFFFFFF
08 3 000000F0
0C 4 12345678
10 5 EDCBA987
14 6 12345768
18 7 EDCBAA78
1C 8 00000268
20 9 123450F0
24 A 00000110
28 0 00000000
2C 0 00000000
30 B 12345678
34 0 00000000
3C D 00000040
80 0 00000000
84 0 00000000
88 0 00000000
90 F 00000001
94 0 00000000
98 0 00000000
40 E 00000055
44 0 00000000
9C 0 00000000
1 0
// Second section with an illegal word at 0x04
3
00 00300093
04 FFFFFFFF
08 00100073
1
00 1 00000003
0 1
